/* flist.f */
rtl/bus_pkg.sv
rtl/soc_pkg.sv
rtl/xbar_arbiter.sv
rtl/xbar.sv
rtl/hart_stub.sv
rtl/scratch_ram.sv
rtl/soc.sv
verif/tb_clk.sv
verif/tb_soc.sv

/* Makefile */
TOP = tb_soc

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Result: PASSED$$"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir

/* verif/tb_soc.sv */
// soc testbench
`timescale 1ns/100ps

module tb_soc;

  import bus_pkg::*;
  import soc_pkg::*;

  localparam int HART_WORDS   = 16;
  localparam int SCR_WORDS_T  = 8;
  localparam int RAM_WORDS_T  = 8;
  // ext: two scratch passes, ram writes plus overwrite, reads plus unwritten, window reads
  localparam int EXT_TXN      = 4 * SCR_WORDS_T + 2 * RAM_WORDS_T + 2 + NUM_CORE * HART_WORDS;
  localparam int HART_TXN     = 2 * NUM_CORE * HART_WORDS;
  localparam int TIMEOUT_CYC  = 200 * (EXT_TXN + HART_TXN) + 2000;
  localparam logic [31:0] UNWRITTEN_ADDR = 32'h2000_0000;

  logic                xtal_i;
  logic                rst_i;
  logic                ext_req_valid_i = 1'b0;
  logic                ext_req_ready_o;
  op_e                 ext_req_op_i    = OP_READ;
  logic [ADDR_W-1:0]   ext_req_addr_i  = '0;
  logic [DATA_W-1:0]   ext_req_wdata_i = '0;
  logic                ext_rsp_valid_o;
  logic                ext_rsp_ready_i = 1'b0;
  logic [DATA_W-1:0]   ext_rsp_rdata_o;
  logic                ram_req_valid_o;
  logic                ram_req_ready_i = 1'b0;
  op_e                 ram_req_op_o;
  logic [ADDR_W-1:0]   ram_req_addr_o;
  logic [DATA_W-1:0]   ram_req_wdata_o;
  logic                ram_rsp_valid_i = 1'b0;
  logic                ram_rsp_ready_o;
  logic [DATA_W-1:0]   ram_rsp_rdata_i = '0;
  logic [NUM_CORE-1:0] hart_done_o;
  logic [NUM_CORE-1:0] hart_err_o;

  // error counters and run bookkeeping
  int value_errs = 0;
  int proto_errs = 0;
  int cycle_cnt  = 0;
  int ram_req_cnt = 0;
  int ram_rsp_cnt = 0;
  int ram_outst   = 0;
  logic [31:0] lfsr_q = 32'h1568_2799;

  // ram model state, sparse storage
  logic [31:0] ram_mem [logic [31:0]];
  logic        ram_pend = 1'b0;
  logic [7:0]  ram_delay = '0;
  logic [31:0] ram_rdata_next = '0;

  // expected ram port payload, set by the external master
  op_e         exp_op = OP_READ;
  logic [31:0] exp_addr = '0;
  logic [31:0] exp_wdata = '0;
  // previous cycle of a stalled ram request
  logic        hold_q = 1'b0;
  op_e         hold_op = OP_READ;
  logic [31:0] hold_addr = '0;
  logic [31:0] hold_wdata = '0;
  logic        rst_d = 1'b0;
  logic [NUM_CORE-1:0] err_seen_q = '0;

  tb_clk #(.PERIOD_NS(4.0), .RST_CYCLES(2)) u_clk (.xtal_o(xtal_i), .rst_o(rst_i));

  soc #(
    .HART_WORDS (HART_WORDS)
  ) soc_i (
    .xtal_i          (xtal_i),
    .rst_i           (rst_i),
    .ext_req_valid_i (ext_req_valid_i),
    .ext_req_ready_o (ext_req_ready_o),
    .ext_req_op_i    (ext_req_op_i),
    .ext_req_addr_i  (ext_req_addr_i),
    .ext_req_wdata_i (ext_req_wdata_i),
    .ext_rsp_valid_o (ext_rsp_valid_o),
    .ext_rsp_ready_i (ext_rsp_ready_i),
    .ext_rsp_rdata_o (ext_rsp_rdata_o),
    .ram_req_valid_o (ram_req_valid_o),
    .ram_req_ready_i (ram_req_ready_i),
    .ram_req_op_o    (ram_req_op_o),
    .ram_req_addr_o  (ram_req_addr_o),
    .ram_req_wdata_o (ram_req_wdata_o),
    .ram_rsp_valid_i (ram_rsp_valid_i),
    .ram_rsp_ready_o (ram_rsp_ready_o),
    .ram_rsp_rdata_i (ram_rsp_rdata_i),
    .hart_done_o     (hart_done_o),
    .hart_err_o      (hart_err_o)
  );

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] r;
    logic       fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[6:0], fb};
    end
    return r;
  endfunction

  // hart h word k holds A500_0000 + h*256 + k
  function automatic logic [31:0] expected_pattern(input int h, input int k);
    return 32'hA500_0000 + 32'(h * 256 + k);
  endfunction

  function automatic logic [31:0] scratch_addr(input int w);
    return SCRATCH_BASE + 32'(w * 4);
  endfunction

  function automatic logic [31:0] scratch_data(input int w);
    return 32'h3C00_0000 + 32'(w) * 32'h0001_0101;
  endfunction

  // even words below the scratchpad, odd words just past its end
  function automatic logic [31:0] ram_test_addr(input int i);
    return ((i % 2 == 0) ? 32'h0000_0400 : 32'h1000_0400) + 32'(i * 4);
  endfunction

  function automatic logic [31:0] ram_test_data(input int i);
    return 32'h6B00_0000 + 32'(i) * 32'h0003_0107;
  endfunction

  // unwritten words read back as a function of the whole address
  function automatic logic [31:0] ram_lookup(input logic [31:0] addr);
    if (ram_mem.exists(addr)) begin
      return ram_mem[addr];
    end
    return addr ^ 32'h5A5A_A5A5;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    value_errs++;
    $display("ERR %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
  endtask

  task automatic report_failure(input string msg);
    proto_errs++;
    $display("failure at %0t: %s", $time, msg);
  endtask

  task automatic print_counts();
    $display("errors: value %0d protocol %0d, ram requests %0d responses %0d",
             value_errs, proto_errs, ram_req_cnt, ram_rsp_cnt);
  endtask

  // one external transaction, request then response
  task automatic ext_access(input op_e op, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    exp_op    = op;
    exp_addr  = addr;
    exp_wdata = wdata;
    @(posedge xtal_i);
    ext_req_valid_i <= 1'b1;
    ext_req_op_i    <= op;
    ext_req_addr_i  <= addr;
    ext_req_wdata_i <= wdata;
    ext_rsp_ready_i <= 1'b1;
    do @(posedge xtal_i); while (!ext_req_ready_o);
    ext_req_valid_i <= 1'b0;
    do @(posedge xtal_i); while (!ext_rsp_valid_o);
    rdata = ext_rsp_rdata_o;
    ext_rsp_ready_i <= 1'b0;
  endtask

  task automatic ext_write(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] unused_rdata;
    ext_access(OP_WRITE, addr, wdata, unused_rdata);
  endtask

  task automatic ext_read(input logic [31:0] addr, output logic [31:0] rdata);
    ext_access(OP_READ, addr, 32'h0, rdata);
  endtask

  // unused scratchpad words, written then read back
  task automatic scratch_readback(input int first, input int count);
    logic [31:0] rdata;
    for (int w = first; w < first + count; w++) begin
      ext_write(scratch_addr(w), scratch_data(w));
    end
    for (int w = first; w < first + count; w++) begin
      ext_read(scratch_addr(w), rdata);
      assert (rdata == scratch_data(w))
        else report_mismatch("ext_rsp_rdata_o", rdata, scratch_data(w));
    end
  endtask

  // writes through the ram port, word 0 overwritten once
  task automatic ram_port_test();
    logic [31:0] rdata;
    logic [31:0] exp;
    for (int i = 0; i < RAM_WORDS_T; i++) begin
      ext_write(ram_test_addr(i), ram_test_data(i));
    end
    ext_write(ram_test_addr(0), ~ram_test_data(0));
    for (int i = 0; i < RAM_WORDS_T; i++) begin
      exp = (i == 0) ? ~ram_test_data(0) : ram_test_data(i);
      ext_read(ram_test_addr(i), rdata);
      assert (rdata == exp) else report_mismatch("ext_rsp_rdata_o", rdata, exp);
    end
    ext_read(UNWRITTEN_ADDR, rdata);
    assert (rdata == (UNWRITTEN_ADDR ^ 32'h5A5A_A5A5))
      else report_mismatch("ext_rsp_rdata_o", rdata, UNWRITTEN_ADDR ^ 32'h5A5A_A5A5);
  endtask

  task automatic hart_window_check();
    logic [31:0] rdata;
    for (int h = 0; h < NUM_CORE; h++) begin
      for (int k = 0; k < HART_WORDS; k++) begin
        ext_read(scratch_addr(h * HART_WIN_WORDS + k), rdata);
        assert (rdata == expected_pattern(h, k))
          else report_mismatch("ext_rsp_rdata_o", rdata, expected_pattern(h, k));
      end
    end
  endtask

  // ram model with random ready and response delay
  always @(posedge xtal_i) begin
    if (rst_i) begin
      ram_req_ready_i <= 1'b0;
      ram_rsp_valid_i <= 1'b0;
      ram_pend        <= 1'b0;
    end else begin
      ram_req_ready_i <= (rand_bits(1) != 8'd0);
      if (ram_req_valid_o && ram_req_ready_i) begin
        ram_pend  <= 1'b1;
        ram_delay <= rand_bits(2);
        if (ram_req_op_o == OP_WRITE) begin
          ram_mem[ram_req_addr_o] = ram_req_wdata_o;
          ram_rdata_next <= '0;
        end else begin
          ram_rdata_next <= ram_lookup(ram_req_addr_o);
        end
      end else if (ram_pend && !ram_rsp_valid_i) begin
        if (ram_delay == 8'd0) begin
          ram_rsp_valid_i <= 1'b1;
          ram_rsp_rdata_i <= ram_rdata_next;
          ram_pend        <= 1'b0;
        end else begin
          ram_delay <= ram_delay - 8'd1;
        end
      end
      if (ram_rsp_valid_i && ram_rsp_ready_o) begin
        ram_rsp_valid_i <= 1'b0;
      end
    end
  end

  // ram port protocol and payload checks
  always @(posedge xtal_i) begin
    if (rst_i) begin
      hold_q    <= 1'b0;
      ram_outst <= 0;
    end else begin
      if (hold_q) begin
        assert (ram_req_valid_o) else report_failure("ram request valid dropped before ready");
        assert (ram_req_op_o == hold_op)
          else report_mismatch("ram_req_op_o", 32'(ram_req_op_o), 32'(hold_op));
        assert (ram_req_addr_o == hold_addr)
          else report_mismatch("ram_req_addr_o", ram_req_addr_o, hold_addr);
        assert (ram_req_wdata_o == hold_wdata)
          else report_mismatch("ram_req_wdata_o", ram_req_wdata_o, hold_wdata);
      end
      hold_q     <= ram_req_valid_o && !ram_req_ready_i;
      hold_op    <= ram_req_op_o;
      hold_addr  <= ram_req_addr_o;
      hold_wdata <= ram_req_wdata_o;
      if (ram_req_valid_o && ram_req_ready_i) begin
        assert (ram_outst == 0) else report_failure("ram request accepted before last response");
        assert (ram_req_op_o == exp_op)
          else report_mismatch("ram_req_op_o", 32'(ram_req_op_o), 32'(exp_op));
        assert (ram_req_addr_o == exp_addr)
          else report_mismatch("ram_req_addr_o", ram_req_addr_o, exp_addr);
        if (exp_op == OP_WRITE) begin
          assert (ram_req_wdata_o == exp_wdata)
            else report_mismatch("ram_req_wdata_o", ram_req_wdata_o, exp_wdata);
        end
        ram_req_cnt <= ram_req_cnt + 1;
      end
      if (ram_rsp_valid_i && ram_rsp_ready_o) begin
        assert (ram_outst == 1) else report_failure("ram response with no request pending");
        ram_rsp_cnt <= ram_rsp_cnt + 1;
      end
      ram_outst <= ram_outst + ((ram_req_valid_o && ram_req_ready_i) ? 1 : 0)
                             - ((ram_rsp_valid_i && ram_rsp_ready_o) ? 1 : 0);
    end
  end

  // quiet outputs during reset and one cycle after, err never rises
  always @(posedge xtal_i) begin
    rst_d <= rst_i;
    if (rst_d) begin
      assert (ram_req_valid_o == 1'b0)
        else report_mismatch("ram_req_valid_o", 32'(ram_req_valid_o), 32'h0);
      assert (ext_rsp_valid_o == 1'b0)
        else report_mismatch("ext_rsp_valid_o", 32'(ext_rsp_valid_o), 32'h0);
      assert (hart_done_o == '0) else report_mismatch("hart_done_o", 32'(hart_done_o), 32'h0);
      assert (hart_err_o == '0) else report_mismatch("hart_err_o", 32'(hart_err_o), 32'h0);
    end else if (!rst_i && hart_err_o != err_seen_q) begin
      assert (hart_err_o == '0) else report_mismatch("hart_err_o", 32'(hart_err_o), 32'h0);
    end
    err_seen_q <= hart_err_o;
  end

  // run limit scaled by the number of transactions
  always @(posedge xtal_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("timeout after %0d cycles, the test did not complete", cycle_cnt);
      print_counts();
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    @(negedge rst_i);
    @(posedge xtal_i);
    // harts are running, so these contend for the scratchpad
    scratch_readback(4 * HART_WIN_WORDS, SCR_WORDS_T);
    ram_port_test();
    while (hart_done_o != {NUM_CORE{1'b1}}) @(posedge xtal_i);
    assert (hart_err_o == '0) else report_mismatch("hart_err_o", 32'(hart_err_o), 32'h0);
    hart_window_check();
    scratch_readback(200, SCR_WORDS_T);
    @(posedge xtal_i);
    assert (ram_req_cnt == ram_rsp_cnt)
      else report_failure($sformatf("%0d ram requests but %0d responses",
                                    ram_req_cnt, ram_rsp_cnt));
    print_counts();
    if (value_errs == 0 && proto_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* verif/tb_clk.sv */
// testbench clock and reset
`timescale 1ns/100ps

module tb_clk #(
  parameter real PERIOD_NS  = 4.0,
  parameter int  RST_CYCLES = 2
) (
  output logic xtal_o,
  output logic rst_o
);

  // free running clock
  initial begin
    xtal_o = 1'b0;
    forever #(PERIOD_NS / 2.0) xtal_o = ~xtal_o;
  end

  // reset released on a rising edge
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge xtal_o);
    rst_o <= 1'b0;
  end

endmodule

/* rtl/soc.sv */
// soc top with harts, crossbar and scratchpad
`timescale 1ns/100ps

module soc #(
  parameter int HART_WORDS = 16
) (
  input  logic                           xtal_i,
  input  logic                           rst_i,
  // external master
  input  logic                           ext_req_valid_i,
  output logic                           ext_req_ready_o,
  input  bus_pkg::op_e                   ext_req_op_i,
  input  logic [bus_pkg::ADDR_W-1:0]     ext_req_addr_i,
  input  logic [bus_pkg::DATA_W-1:0]     ext_req_wdata_i,
  output logic                           ext_rsp_valid_o,
  input  logic                           ext_rsp_ready_i,
  output logic [bus_pkg::DATA_W-1:0]     ext_rsp_rdata_o,
  // external ram port
  output logic                           ram_req_valid_o,
  input  logic                           ram_req_ready_i,
  output bus_pkg::op_e                   ram_req_op_o,
  output logic [bus_pkg::ADDR_W-1:0]     ram_req_addr_o,
  output logic [bus_pkg::DATA_W-1:0]     ram_req_wdata_o,
  input  logic                           ram_rsp_valid_i,
  output logic                           ram_rsp_ready_o,
  input  logic [bus_pkg::DATA_W-1:0]     ram_rsp_rdata_i,
  // hart status
  output logic [soc_pkg::NUM_CORE-1:0]   hart_done_o,
  output logic [soc_pkg::NUM_CORE-1:0]   hart_err_o
);

  import bus_pkg::*;
  import soc_pkg::*;

  logic [NUM_MASTERS-1:0]             m_req_valid;
  logic [NUM_MASTERS-1:0]             m_req_ready;
  op_e  [NUM_MASTERS-1:0]             m_req_op;
  logic [NUM_MASTERS-1:0][ADDR_W-1:0] m_req_addr;
  logic [NUM_MASTERS-1:0][DATA_W-1:0] m_req_wdata;
  logic [NUM_MASTERS-1:0]             m_rsp_valid;
  logic [NUM_MASTERS-1:0]             m_rsp_ready;
  logic [NUM_MASTERS-1:0][DATA_W-1:0] m_rsp_rdata;

  logic [NUM_SLAVES-1:0]              s_req_valid;
  logic [NUM_SLAVES-1:0]              s_req_ready;
  op_e  [NUM_SLAVES-1:0]              s_req_op;
  logic [NUM_SLAVES-1:0][ADDR_W-1:0]  s_req_addr;
  logic [NUM_SLAVES-1:0][DATA_W-1:0]  s_req_wdata;
  logic [NUM_SLAVES-1:0]              s_rsp_valid;
  logic [NUM_SLAVES-1:0]              s_rsp_ready;
  logic [NUM_SLAVES-1:0][DATA_W-1:0]  s_rsp_rdata;

  // external master on the last crossbar port
  assign m_req_valid[EXT_MASTER] = ext_req_valid_i;
  assign m_req_op[EXT_MASTER]    = ext_req_op_i;
  assign m_req_addr[EXT_MASTER]  = ext_req_addr_i;
  assign m_req_wdata[EXT_MASTER] = ext_req_wdata_i;
  assign m_rsp_ready[EXT_MASTER] = ext_rsp_ready_i;
  assign ext_req_ready_o         = m_req_ready[EXT_MASTER];
  assign ext_rsp_valid_o         = m_rsp_valid[EXT_MASTER];
  assign ext_rsp_rdata_o         = m_rsp_rdata[EXT_MASTER];

  // ram port is slave 0 and the default target
  assign ram_req_valid_o         = s_req_valid[SLV_RAM];
  assign ram_req_op_o            = s_req_op[SLV_RAM];
  assign ram_req_addr_o          = s_req_addr[SLV_RAM];
  assign ram_req_wdata_o         = s_req_wdata[SLV_RAM];
  assign ram_rsp_ready_o         = s_rsp_ready[SLV_RAM];
  assign s_req_ready[SLV_RAM]    = ram_req_ready_i;
  assign s_rsp_valid[SLV_RAM]    = ram_rsp_valid_i;
  assign s_rsp_rdata[SLV_RAM]    = ram_rsp_rdata_i;

  for (genvar core = 0; core < NUM_CORE; core++) begin : g_cores
    hart_stub #(
      .NUM_WORDS (HART_WORDS)
    ) u_hart (
      .xtal_i      (xtal_i),
      .rst_i       (rst_i),
      .hart_id_i   (HART_ID_W'(core)),
      .req_valid_o (m_req_valid[core]),
      .req_ready_i (m_req_ready[core]),
      .req_op_o    (m_req_op[core]),
      .req_addr_o  (m_req_addr[core]),
      .req_wdata_o (m_req_wdata[core]),
      .rsp_valid_i (m_rsp_valid[core]),
      .rsp_ready_o (m_rsp_ready[core]),
      .rsp_rdata_i (m_rsp_rdata[core]),
      .done_o      (hart_done_o[core]),
      .err_o       (hart_err_o[core])
    );
  end

  xbar u_xbar (
    .xtal_i        (xtal_i),
    .rst_i         (rst_i),
    .m_req_valid_i (m_req_valid),
    .m_req_ready_o (m_req_ready),
    .m_req_op_i    (m_req_op),
    .m_req_addr_i  (m_req_addr),
    .m_req_wdata_i (m_req_wdata),
    .m_rsp_valid_o (m_rsp_valid),
    .m_rsp_ready_i (m_rsp_ready),
    .m_rsp_rdata_o (m_rsp_rdata),
    .s_req_valid_o (s_req_valid),
    .s_req_ready_i (s_req_ready),
    .s_req_op_o    (s_req_op),
    .s_req_addr_o  (s_req_addr),
    .s_req_wdata_o (s_req_wdata),
    .s_rsp_valid_i (s_rsp_valid),
    .s_rsp_ready_o (s_rsp_ready),
    .s_rsp_rdata_i (s_rsp_rdata)
  );

  scratch_ram #(
    .DEPTH (SCRATCH_WORDS)
  ) u_scratch (
    .xtal_i      (xtal_i),
    .rst_i       (rst_i),
    .req_valid_i (s_req_valid[SLV_SCRATCH]),
    .req_ready_o (s_req_ready[SLV_SCRATCH]),
    .req_op_i    (s_req_op[SLV_SCRATCH]),
    .req_addr_i  (s_req_addr[SLV_SCRATCH]),
    .req_wdata_i (s_req_wdata[SLV_SCRATCH]),
    .rsp_valid_o (s_rsp_valid[SLV_SCRATCH]),
    .rsp_ready_i (s_rsp_ready[SLV_SCRATCH]),
    .rsp_rdata_o (s_rsp_rdata[SLV_SCRATCH])
  );

endmodule

/* rtl/scratch_ram.sv */
// on-chip scratchpad, single port
`timescale 1ns/100ps

module scratch_ram #(
  parameter int DEPTH = 256
) (
  input  logic                       xtal_i,
  input  logic                       rst_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  bus_pkg::op_e               req_op_i,
  input  logic [bus_pkg::ADDR_W-1:0] req_addr_i,
  input  logic [bus_pkg::DATA_W-1:0] req_wdata_i,
  output logic                       rsp_valid_o,
  input  logic                       rsp_ready_i,
  output logic [bus_pkg::DATA_W-1:0] rsp_rdata_o
);

  import bus_pkg::*;

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [DATA_W-1:0] mem [DEPTH];
  logic [AW-1:0]     word_idx;
  logic              accept;
  logic              rsp_valid_q;
  logic [DATA_W-1:0] rdata_q;

  // word index sits just above the byte offset
  assign word_idx    = req_addr_i[BYTE_OFS_W +: AW];
  // single pending response, stall until it drains
  assign req_ready_o = !rsp_valid_q;
  assign accept      = req_valid_i & req_ready_o;

  always_ff @(posedge xtal_i) begin
    if (accept && req_op_i == OP_WRITE) begin
      mem[word_idx] <= req_wdata_i;
    end
  end

  // write returns zero data
  always_ff @(posedge xtal_i) begin
    if (accept) begin
      rdata_q <= (req_op_i == OP_WRITE) ? '0 : mem[word_idx];
    end
  end

  always_ff @(posedge xtal_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_rdata_o = rdata_q;

endmodule

/* rtl/hart_stub.sv */
// hart stand-in, write then verify
`timescale 1ns/100ps

module hart_stub #(
  parameter int NUM_WORDS = 16
) (
  input  logic                          xtal_i,
  input  logic                          rst_i,
  input  logic [soc_pkg::HART_ID_W-1:0] hart_id_i,
  output logic                          req_valid_o,
  input  logic                          req_ready_i,
  output bus_pkg::op_e                  req_op_o,
  output logic [bus_pkg::ADDR_W-1:0]    req_addr_o,
  output logic [bus_pkg::DATA_W-1:0]    req_wdata_o,
  input  logic                          rsp_valid_i,
  output logic                          rsp_ready_o,
  input  logic [bus_pkg::DATA_W-1:0]    rsp_rdata_i,
  output logic                          done_o,
  output logic                          err_o
);

  import bus_pkg::*;
  import soc_pkg::*;

  localparam int IDX_W = $clog2(HART_WIN_WORDS);

  typedef enum logic [1:0] {
    ST_WRITE,
    ST_READ,
    ST_DONE
  } state_e;

  state_e           state_q;
  logic [IDX_W-1:0] idx_q;
  logic             req_valid_q;
  // request accepted, response not yet back
  logic             wait_q;
  logic             err_q;

  always_ff @(posedge xtal_i) begin
    if (rst_i) begin
      state_q     <= ST_WRITE;
      idx_q       <= '0;
      req_valid_q <= 1'b0;
      wait_q      <= 1'b0;
      err_q       <= 1'b0;
    end else if (state_q != ST_DONE) begin
      // one request at a time, raised when idle
      if (!req_valid_q && !wait_q) begin
        req_valid_q <= 1'b1;
      end
      if (req_valid_q && req_ready_i) begin
        req_valid_q <= 1'b0;
        wait_q      <= 1'b1;
      end
      if (wait_q && rsp_valid_i) begin
        wait_q <= 1'b0;
        // read data checked against the pattern, error is sticky
        if (state_q == ST_READ && rsp_rdata_i != req_wdata_o) begin
          err_q <= 1'b1;
        end
        if (idx_q == IDX_W'(NUM_WORDS - 1)) begin
          idx_q   <= '0;
          state_q <= (state_q == ST_WRITE) ? ST_READ : ST_DONE;
        end else begin
          idx_q <= idx_q + 1'b1;
        end
      end
    end
  end

  assign req_valid_o = req_valid_q;
  assign req_op_o    = (state_q == ST_WRITE) ? OP_WRITE : OP_READ;
  assign req_addr_o  = hart_addr(32'(hart_id_i), 32'(idx_q));
  // also the expected read value during the read phase
  assign req_wdata_o = hart_pattern(32'(hart_id_i), 32'(idx_q));
  assign rsp_ready_o = wait_q;
  assign done_o      = (state_q == ST_DONE);
  assign err_o       = err_q;

endmodule

/* rtl/xbar.sv */
// request crossbar, masters to slaves
`timescale 1ns/100ps

module xbar (
  input  logic                                                 xtal_i,
  input  logic                                                 rst_i,
  // master side
  input  logic [soc_pkg::NUM_MASTERS-1:0]                      m_req_valid_i,
  output logic [soc_pkg::NUM_MASTERS-1:0]                      m_req_ready_o,
  input  bus_pkg::op_e [soc_pkg::NUM_MASTERS-1:0]              m_req_op_i,
  input  logic [soc_pkg::NUM_MASTERS-1:0][bus_pkg::ADDR_W-1:0] m_req_addr_i,
  input  logic [soc_pkg::NUM_MASTERS-1:0][bus_pkg::DATA_W-1:0] m_req_wdata_i,
  output logic [soc_pkg::NUM_MASTERS-1:0]                      m_rsp_valid_o,
  input  logic [soc_pkg::NUM_MASTERS-1:0]                      m_rsp_ready_i,
  output logic [soc_pkg::NUM_MASTERS-1:0][bus_pkg::DATA_W-1:0] m_rsp_rdata_o,
  // slave side
  output logic [soc_pkg::NUM_SLAVES-1:0]                       s_req_valid_o,
  input  logic [soc_pkg::NUM_SLAVES-1:0]                       s_req_ready_i,
  output bus_pkg::op_e [soc_pkg::NUM_SLAVES-1:0]               s_req_op_o,
  output logic [soc_pkg::NUM_SLAVES-1:0][bus_pkg::ADDR_W-1:0]  s_req_addr_o,
  output logic [soc_pkg::NUM_SLAVES-1:0][bus_pkg::DATA_W-1:0]  s_req_wdata_o,
  input  logic [soc_pkg::NUM_SLAVES-1:0]                       s_rsp_valid_i,
  output logic [soc_pkg::NUM_SLAVES-1:0]                       s_rsp_ready_o,
  input  logic [soc_pkg::NUM_SLAVES-1:0][bus_pkg::DATA_W-1:0]  s_rsp_rdata_i
);

  import bus_pkg::*;
  import soc_pkg::*;

  localparam int SLV_W = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;

  // target slave of each master
  logic [NUM_MASTERS-1:0][SLV_W-1:0]      m_sel;
  logic [NUM_SLAVES-1:0][NUM_MASTERS-1:0] arb_req;
  logic [NUM_SLAVES-1:0][NUM_MASTERS-1:0] arb_gnt;
  logic [NUM_SLAVES-1:0]                  arb_busy;
  logic [NUM_SLAVES-1:0]                  rsp_done;

  // scratchpad window, everything else goes to the ram port
  always_comb begin
    for (int m = 0; m < NUM_MASTERS; m++) begin
      if (m_req_addr_i[m] >= SCRATCH_BASE && m_req_addr_i[m] < SCRATCH_END) begin
        m_sel[m] = SLV_W'(SLV_SCRATCH);
      end else begin
        m_sel[m] = SLV_W'(SLV_RAM);
      end
    end
  end

  // per slave request vectors
  always_comb begin
    for (int s = 0; s < NUM_SLAVES; s++) begin
      for (int m = 0; m < NUM_MASTERS; m++) begin
        arb_req[s][m] = m_req_valid_i[m] && (m_sel[m] == SLV_W'(s));
      end
    end
  end

  for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_arb
    // release once the response handshake completes
    assign rsp_done[s] = s_rsp_valid_i[s] & s_rsp_ready_o[s];

    xbar_arbiter #(
      .N (NUM_MASTERS)
    ) u_arb (
      .xtal_i (xtal_i),
      .rst_i  (rst_i),
      .req_i  (arb_req[s]),
      .done_i (rsp_done[s]),
      .gnt_o  (arb_gnt[s]),
      .busy_o (arb_busy[s])
    );
  end

  // granted master drives the slave request
  // response ready only once the grant is locked
  always_comb begin
    for (int s = 0; s < NUM_SLAVES; s++) begin
      s_req_valid_o[s] = 1'b0;
      s_req_op_o[s]    = OP_READ;
      s_req_addr_o[s]  = '0;
      s_req_wdata_o[s] = '0;
      s_rsp_ready_o[s] = 1'b0;
      for (int m = 0; m < NUM_MASTERS; m++) begin
        if (arb_gnt[s][m]) begin
          s_req_valid_o[s] = arb_req[s][m];
          s_req_op_o[s]    = m_req_op_i[m];
          s_req_addr_o[s]  = m_req_addr_i[m];
          s_req_wdata_o[s] = m_req_wdata_i[m];
          s_rsp_ready_o[s] = arb_busy[s] & m_rsp_ready_i[m];
        end
      end
    end
  end

  // ready and response back to the owning master
  always_comb begin
    for (int m = 0; m < NUM_MASTERS; m++) begin
      m_req_ready_o[m] = 1'b0;
      m_rsp_valid_o[m] = 1'b0;
      m_rsp_rdata_o[m] = '0;
      for (int s = 0; s < NUM_SLAVES; s++) begin
        if (arb_gnt[s][m] && arb_req[s][m]) begin
          m_req_ready_o[m] = s_req_ready_i[s];
        end
        if (arb_gnt[s][m] && arb_busy[s] && s_rsp_valid_i[s]) begin
          m_rsp_valid_o[m] = 1'b1;
          m_rsp_rdata_o[m] = s_rsp_rdata_i[s];
        end
      end
    end
  end

endmodule

/* rtl/xbar_arbiter.sv */
// round-robin arbiter with locked grant
`timescale 1ns/100ps

module xbar_arbiter #(
  parameter int N = 2
) (
  input  logic         xtal_i,
  input  logic         rst_i,
  input  logic [N-1:0] req_i,
  input  logic         done_i,
  output logic [N-1:0] gnt_o,
  output logic         busy_o
);

  localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

  // index of the last winner, search starts one above it
  logic [IDX_W-1:0] last_q;
  logic [IDX_W-1:0] win_idx;
  logic [N-1:0]     gnt_new;
  // grant held while a transaction is in flight
  logic [N-1:0]     gnt_q;
  logic             busy_q;

  // pick the first requester after the last winner
  always_comb begin
    int   cand;
    logic found;
    gnt_new = '0;
    win_idx = last_q;
    found   = 1'b0;
    for (int i = 1; i <= N; i++) begin
      cand = (int'(last_q) + i) % N;
      if (!found && req_i[cand]) begin
        found         = 1'b1;
        gnt_new[cand] = 1'b1;
        win_idx       = IDX_W'(cand);
      end
    end
  end

  // lock on first request, release on response handshake
  always_ff @(posedge xtal_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      gnt_q  <= '0;
      // first search after reset begins at master 0
      last_q <= IDX_W'(N - 1);
    end else if (busy_q) begin
      if (done_i) begin
        busy_q <= 1'b0;
        gnt_q  <= '0;
      end
    end else if (|req_i) begin
      busy_q <= 1'b1;
      gnt_q  <= gnt_new;
      last_q <= win_idx;
    end
  end

  // idle slave grants in the same cycle as the request
  assign gnt_o  = busy_q ? gnt_q : gnt_new;
  assign busy_o = busy_q;

endmodule

/* rtl/soc_pkg.sv */
// system configuration and address map
package soc_pkg;

  // harts plus one external master on the last index
  parameter int NUM_CORE    = 4;
  parameter int NUM_MASTERS = NUM_CORE + 1;
  parameter int EXT_MASTER  = NUM_MASTERS - 1;
  parameter int HART_ID_W   = (NUM_CORE > 1) ? $clog2(NUM_CORE) : 1;

  // slave indices, ram port doubles as the default target
  parameter int NUM_SLAVES  = 2;
  parameter int SLV_RAM     = 0;
  parameter int SLV_SCRATCH = 1;

  // scratchpad window, end address is exclusive
  parameter logic [bus_pkg::ADDR_W-1:0] SCRATCH_BASE = 32'h1000_0000;
  parameter int SCRATCH_WORDS = 256;
  parameter logic [bus_pkg::ADDR_W-1:0] SCRATCH_END =
    SCRATCH_BASE + bus_pkg::ADDR_W'(SCRATCH_WORDS * bus_pkg::WORD_BYTES);

  // each hart owns a slice of the scratchpad
  parameter int HART_WIN_WORDS = 16;

  // expected content of word idx inside the window of a hart
  function automatic logic [bus_pkg::DATA_W-1:0] hart_pattern(input int unsigned hart,
                                                              input int unsigned idx);
    return bus_pkg::DATA_W'(32'hA500_0000 + hart * 256 + idx);
  endfunction

  // byte address of word idx inside the window of a hart
  function automatic logic [bus_pkg::ADDR_W-1:0] hart_addr(input int unsigned hart,
                                                           input int unsigned idx);
    return SCRATCH_BASE +
      bus_pkg::ADDR_W'((hart * HART_WIN_WORDS + idx) * bus_pkg::WORD_BYTES);
  endfunction

endpackage

/* rtl/bus_pkg.sv */
// request and response bus definitions
package bus_pkg;

  // address width in bits, byte addressed
  parameter int ADDR_W = 32;

  // data width of one bus word
  parameter int DATA_W = 32;

  // bytes per bus word, used for word index extraction
  parameter int WORD_BYTES = DATA_W / 8;

  // low address bits that select a byte inside a word
  parameter int BYTE_OFS_W = $clog2(WORD_BYTES);

  // request opcode, a single bit on the request channel
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

endpackage
